// ==== bench/uart_bench_lib.svh ====
// ====================
// UART testbench helpers
// LFSR, reference frame and compare tasks
// ====================
`ifndef UART_BENCH_LIB_SVH
`define UART_BENCH_LIB_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	logic feedback;
	feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
	return {state[30:0], feedback};
endfunction

// Line levels in send order: low start, data LSB first, high stop
function automatic logic [9:0] uart_frame(input uart_char_t c);
	logic [9:0] frame;
	frame[0] = 1'b0;
	for (int i = 0; i < 8; i++)
		frame[i + 1] = c[i];
	frame[9] = 1'b1;
	return frame;
endfunction

task automatic compare_char(input string test_name, input uart_char_t expected,
	input uart_char_t actual);
	if (actual !== expected)
	begin
		$display("[ERROR] %s: expected 0x%02h, actual 0x%02h", test_name, expected, actual);
		end_with_failure();
	end
endtask

task automatic compare_flag(input string test_name, input logic expected,
	input logic actual);
	if (actual !== expected)
	begin
		$display("[ERROR] %s: expected %b, actual %b", test_name, expected, actual);
		end_with_failure();
	end
endtask

`endif

// ==== bench/uart_core_tb.sv ====
// ====================
// UART core testbench
// Serial receive, FIFO overrun and transmit framing checks
// ====================
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_core_tb;

	import uart_pkg::*;

	localparam int BIT_CLOCKS = 8 * `UART_BAUD_DIVIDE;
	localparam int WAIT_LIMIT = 20 * BIT_CLOCKS;
	localparam int FIFO_DEPTH = 1 << `UART_FIFO_ADDR_BITS;
	localparam int TX_FRAMES = 8;

	logic clk;
	logic reset;
	logic uart_rx;
	logic rx_read;
	uart_char_t rx_data;
	logic rx_frame_error;
	logic rx_empty;
	logic rx_overrun;
	uart_char_t tx_data;
	logic tx_write;
	logic uart_tx;
	logic tx_busy;

	logic [31:0] lfsr_state;
	uart_char_t sent[$];
	uart_char_t tx_expected[$];

	// Transmit monitor state
	logic mon_active;
	logic tx_busy_prev;
	logic [9:0] mon_frame;
	int mon_clock;
	int mon_bit;
	int frames_checked;

	uart_core dut(
		.clk(clk),
		.reset(reset),
		.uart_rx(uart_rx),
		.rx_read(rx_read),
		.rx_data(rx_data),
		.rx_frame_error(rx_frame_error),
		.rx_empty(rx_empty),
		.rx_overrun(rx_overrun),
		.tx_data(tx_data),
		.tx_write(tx_write),
		.uart_tx(uart_tx),
		.tx_busy(tx_busy));

	task automatic end_with_failure();
		$display("Testbench failed");
		$fatal(1, "Stopping at the first error");
	endtask

	`include "uart_bench_lib.svh"

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// One random bit per LFSR step
	task automatic random_char(output uart_char_t c);
		for (int i = 0; i < 8; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			c[i] = lfsr_state[0];
		end
	endtask

	// Drives one frame, then leaves the line idle for a bit
	task automatic send_frame(input uart_char_t c, input logic stop_bit);
		logic [9:0] bits;
		bits = uart_frame(c);
		bits[9] = stop_bit;
		@(posedge clk);
		for (int i = 0; i < 10; i++)
		begin
			uart_rx <= bits[i];
			repeat (BIT_CLOCKS) @(posedge clk);
		end
		uart_rx <= 1'b1;
		repeat (BIT_CLOCKS) @(posedge clk);
	endtask

	task automatic wait_for_character(input string test_name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (rx_empty && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (rx_empty)
		begin
			$display("Timeout in %s: no character reached the receive FIFO", test_name);
			end_with_failure();
		end
	endtask

	task automatic wait_tx_level(input string test_name, input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (tx_busy !== level && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (tx_busy !== level)
		begin
			$display("Timeout in %s: tx_busy never went to %b", test_name, level);
			end_with_failure();
		end
	endtask

	// Pops the head entry, then lets the outputs settle
	task automatic pop_char();
		@(posedge clk);
		rx_read <= 1'b1;
		@(posedge clk);
		rx_read <= 1'b0;
		@(negedge clk);
	endtask

	task automatic receive_good_frames();
		uart_char_t c;
		for (int n = 0; n < 12; n++)
		begin
			random_char(c);
			send_frame(c, 1'b1);
			wait_for_character("reception");
			compare_char("reception data", c, rx_data);
			compare_flag("reception frame error", 1'b0, rx_frame_error);
			pop_char();
			compare_flag("reception empty after read", 1'b1, rx_empty);
		end
	endtask

	task automatic receive_bad_stop();
		uart_char_t c;
		random_char(c);
		send_frame(c, 1'b0);
		wait_for_character("framing error");
		compare_char("framing error data", c, rx_data);
		compare_flag("framing error flag", 1'b1, rx_frame_error);
		pop_char();
	endtask

	// Low pulse of a quarter bit must not start a character
	task automatic reject_false_start();
		@(posedge clk);
		uart_rx <= 1'b0;
		repeat (2 * `UART_BAUD_DIVIDE) @(posedge clk);
		uart_rx <= 1'b1;
		repeat (20 * BIT_CLOCKS)
		begin
			@(negedge clk);
			compare_flag("false start", 1'b1, rx_empty);
		end
	endtask

	task automatic overflow_fifo();
		uart_char_t c;
		sent.delete();
		for (int n = 0; n < FIFO_DEPTH + 2; n++)
		begin
			random_char(c);
			sent.push_back(c);
			send_frame(c, 1'b1);
		end
		@(negedge clk);
		compare_flag("overrun set", 1'b1, rx_overrun);
		for (int n = 0; n < FIFO_DEPTH; n++)
		begin
			compare_char("overrun order", sent[n], rx_data);
			pop_char();
			if (n == 0)
				compare_flag("overrun cleared", 1'b0, rx_overrun);
		end
		compare_flag("overrun drained", 1'b1, rx_empty);
	endtask

	// A second strobe lands three bits into each frame and must be ignored
	task automatic transmit_characters();
		uart_char_t c;
		uart_char_t other;
		for (int n = 0; n < TX_FRAMES; n++)
		begin
			random_char(c);
			wait_tx_level("transmission", 1'b0);
			@(posedge clk);
			tx_data <= c;
			tx_write <= 1'b1;
			tx_expected.push_back(c);
			@(posedge clk);
			tx_write <= 1'b0;
			wait_tx_level("transmission", 1'b1);
			repeat (3 * BIT_CLOCKS) @(posedge clk);
			random_char(other);
			tx_data <= other;
			tx_write <= 1'b1;
			@(posedge clk);
			tx_write <= 1'b0;
		end
		wait_tx_level("transmission", 1'b0);
	endtask

	// Samples uart_tx at every bit midpoint after tx_busy rises
	always @(negedge clk)
	begin
		if (reset)
		begin
			mon_active = 1'b0;
			tx_busy_prev = 1'b0;
			frames_checked = 0;
		end
		else
		begin
			if (!mon_active && tx_busy && !tx_busy_prev)
			begin
				if (tx_expected.size() == 0)
				begin
					$display("Transmitter started a frame without an accepted write");
					end_with_failure();
				end
				else
				begin
					mon_frame = uart_frame(tx_expected.pop_front());
					mon_active = 1'b1;
					mon_clock = 0;
					mon_bit = 0;
				end
			end
			else if (mon_active)
			begin
				mon_clock++;
				if (mon_clock == BIT_CLOCKS / 2 + mon_bit * BIT_CLOCKS)
				begin
					compare_flag("transmit frame bit", mon_frame[mon_bit], uart_tx);
					if (mon_bit == 9)
					begin
						mon_active = 1'b0;
						frames_checked++;
					end
					else
						mon_bit++;
				end
			end
			tx_busy_prev = tx_busy;
		end
	end

	initial
	begin
		reset = 1'b1;
		uart_rx = 1'b1;
		rx_read = 1'b0;
		tx_data = '0;
		tx_write = 1'b0;
		lfsr_state = 32'h9b5c;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		compare_flag("reset rx_empty", 1'b1, rx_empty);
		compare_flag("reset rx_overrun", 1'b0, rx_overrun);
		compare_flag("reset tx_busy", 1'b0, tx_busy);
		compare_flag("reset uart_tx", 1'b1, uart_tx);

		receive_good_frames();
		receive_bad_stop();
		reject_false_start();
		overflow_fifo();
		transmit_characters();

		if (frames_checked == TX_FRAMES)
		begin
			$display("Testbench passed");
			$finish;
		end
		else
		begin
			$display("Transmit monitor checked %0d frames instead of %0d",
				frames_checked, TX_FRAMES);
			end_with_failure();
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps \
	--top-module uart_core_tb -f uart_core.f -o uart_core_sim
./obj_dir/uart_core_sim

// ==== src/rx_fifo.sv ====
// ====================
// Receive FIFO, show-ahead
// Holds characters with their framing flag, flags overrun
// ====================
`timescale 1ns/1ps
`include "uart_settings.svh"

module rx_fifo
	(input                          clk,
	input                           reset,
	input uart_pkg::uart_char_t     rx_char,
	input logic                     rx_frame_error_in,
	input logic                     rx_char_valid,
	input logic                     rx_read,
	output uart_pkg::uart_char_t    rx_data,
	output logic                    rx_frame_error,
	output logic                    rx_empty,
	output logic                    rx_overrun);

	import uart_pkg::*;

	localparam int ADDR_BITS = `UART_FIFO_ADDR_BITS;
	localparam int DEPTH = 1 << ADDR_BITS;
	localparam logic [ADDR_BITS:0] FULL_COUNT = {1'b1, {ADDR_BITS{1'b0}}};

	uart_char_t char_mem[DEPTH];
	logic frame_mem[DEPTH];
	logic [ADDR_BITS-1:0] rd_ptr_ff;
	logic [ADDR_BITS-1:0] wr_ptr_ff;
	logic [ADDR_BITS:0] count_ff;
	logic [ADDR_BITS:0] count_nxt;
	logic overrun_ff;
	logic overrun_nxt;
	logic do_read;
	logic do_write;

	assign do_read = rx_read && count_ff != '0;
	// A read in the same cycle frees the slot, so a full FIFO still accepts
	assign do_write = rx_char_valid && (count_ff != FULL_COUNT || do_read);

	always_comb
	begin
		count_nxt = count_ff;
		if (do_write && !do_read)
			count_nxt = count_ff + 1'b1;
		else if (do_read && !do_write)
			count_nxt = count_ff - 1'b1;

		overrun_nxt = overrun_ff;
		if (rx_char_valid && !do_write)
			overrun_nxt = 1'b1;
		else if (do_read)
			overrun_nxt = 1'b0;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr_ff <= '0;
			wr_ptr_ff <= '0;
			count_ff <= '0;
			overrun_ff <= 1'b0;
		end
		else
		begin
			if (do_read)
				rd_ptr_ff <= rd_ptr_ff + 1'b1;
			if (do_write)
				wr_ptr_ff <= wr_ptr_ff + 1'b1;
			count_ff <= count_nxt;
			overrun_ff <= overrun_nxt;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_write)
		begin
			char_mem[wr_ptr_ff] <= rx_char;
			frame_mem[wr_ptr_ff] <= rx_frame_error_in;
		end
	end

	// Head entry is always visible
	assign rx_data = char_mem[rd_ptr_ff];
	assign rx_frame_error = frame_mem[rd_ptr_ff];
	assign rx_empty = count_ff == '0;
	assign rx_overrun = overrun_ff;

endmodule

// ==== src/synchronizer.sv ====
// ====================
// Two-flop synchronizer for an asynchronous input
// ====================
`timescale 1ns/1ps

module synchronizer
	#(parameter logic RESET_STATE = 1'b0)
	(input              clk,
	input               reset,
	input logic         data_i,
	output logic        data_o);

	// First stage may go metastable, second stage settles it
	logic sync_stage;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sync_stage <= RESET_STATE;
			data_o <= RESET_STATE;
		end
		else
		begin
			sync_stage <= data_i;
			data_o <= sync_stage;
		end
	end

endmodule

// ==== src/uart_core.sv ====
// ====================
// UART core
// Receiver into FIFO, plus a single-character transmitter
// ====================
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_core
	(input                          clk,
	input                           reset,

	// Receive side
	input logic                     uart_rx,
	input logic                     rx_read,
	output uart_pkg::uart_char_t    rx_data,
	output logic                    rx_frame_error,
	output logic                    rx_empty,
	output logic                    rx_overrun,

	// Transmit side
	input uart_pkg::uart_char_t     tx_data,
	input logic                     tx_write,
	output logic                    uart_tx,
	output logic                    tx_busy);

	import uart_pkg::*;

	// Receiver to FIFO
	uart_char_t rx_char;
	logic rx_char_valid;
	logic rx_frame_error_in;

	uart_receive u_uart_receive(
		.clk(clk),
		.reset(reset),
		.uart_rx(uart_rx),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.rx_frame_error_in(rx_frame_error_in));

	rx_fifo u_rx_fifo(
		.clk(clk),
		.reset(reset),
		.rx_char(rx_char),
		.rx_frame_error_in(rx_frame_error_in),
		.rx_char_valid(rx_char_valid),
		.rx_read(rx_read),
		.rx_data(rx_data),
		.rx_frame_error(rx_frame_error),
		.rx_empty(rx_empty),
		.rx_overrun(rx_overrun));

	uart_transmit u_uart_transmit(
		.clk(clk),
		.reset(reset),
		.tx_data(tx_data),
		.tx_write(tx_write),
		.uart_tx(uart_tx),
		.tx_busy(tx_busy));

endmodule

// ==== src/uart_pkg.sv ====
// ====================
// UART shared types
// Character type and FSM state encodings
// ====================
package uart_pkg;

	typedef logic [7:0] uart_char_t;

	typedef enum logic [1:0] {
		// Idle, waiting for a falling edge
		RX_WAIT_START,
		// Half a bit in, confirm the start bit is still low
		RX_CHECK_START,
		RX_READ_CHARACTER,
		RX_CHECK_STOP
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START_BIT,
		TX_DATA_BITS,
		TX_STOP_BIT
	} tx_state_t;

endpackage

// ==== src/uart_receive.sv ====
// ====================
// UART receiver
// Oversamples rx at 8x, checks start and stop bits
// ====================
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_receive
	(input                          clk,
	input                           reset,
	input logic                     uart_rx,
	output uart_pkg::uart_char_t    rx_char,
	output logic                    rx_char_valid,
	output logic                    rx_frame_error_in);

	import uart_pkg::*;

	localparam int DIV_BITS = $clog2(`UART_BAUD_DIVIDE + 1);
	localparam logic [DIV_BITS-1:0] DIV_RELOAD = DIV_BITS'(`UART_BAUD_DIVIDE - 1);

	rx_state_t state_ff;
	rx_state_t state_nxt;
	logic [2:0] sample_count_ff;
	logic [2:0] sample_count_nxt;
	logic [2:0] bit_count_ff;
	logic [2:0] bit_count_nxt;
	logic [DIV_BITS-1:0] clock_divider;
	uart_char_t shift_register;
	logic do_shift;
	logic rx_sync;
	logic rx_sync_prev;
	logic sample_enable;

	// Idle line is high, so the synchronizer must come out of reset at 1
	synchronizer #(.RESET_STATE(1'b1)) rx_synchronizer(
		.clk(clk),
		.reset(reset),
		.data_i(uart_rx),
		.data_o(rx_sync));

	assign sample_enable = clock_divider == '0;
	assign rx_char = shift_register;

	// Only meaningful alongside rx_char_valid, when the stop bit is sampled
	assign rx_frame_error_in = !rx_sync;

	always_comb
	begin
		state_nxt = state_ff;
		sample_count_nxt = sample_count_ff;
		bit_count_nxt = bit_count_ff;
		do_shift = 1'b0;
		rx_char_valid = 1'b0;

		unique case (state_ff)
			RX_WAIT_START:
			begin
				// Start on a falling edge, so a line stuck low after a
				// framing error is not taken for a new character
				if (rx_sync_prev && !rx_sync)
				begin
					state_nxt = RX_CHECK_START;
					sample_count_nxt = 3'd3;
				end
			end

			RX_CHECK_START:
			begin
				if (sample_enable)
				begin
					if (sample_count_ff == 3'd0)
					begin
						if (rx_sync)
						begin
							// Glitch shorter than half a bit
							state_nxt = RX_WAIT_START;
						end
						else
						begin
							state_nxt = RX_READ_CHARACTER;
							sample_count_nxt = 3'd7;
							bit_count_nxt = 3'd0;
						end
					end
					else
						sample_count_nxt = sample_count_ff - 3'd1;
				end
			end

			RX_READ_CHARACTER:
			begin
				if (sample_enable)
				begin
					if (sample_count_ff == 3'd0)
					begin
						do_shift = 1'b1;
						sample_count_nxt = 3'd7;
						if (bit_count_ff == 3'd7)
							state_nxt = RX_CHECK_STOP;
						else
							bit_count_nxt = bit_count_ff + 3'd1;
					end
					else
						sample_count_nxt = sample_count_ff - 3'd1;
				end
			end

			RX_CHECK_STOP:
			begin
				if (sample_enable)
				begin
					if (sample_count_ff == 3'd0)
					begin
						rx_char_valid = 1'b1;
						state_nxt = RX_WAIT_START;
					end
					else
						sample_count_nxt = sample_count_ff - 3'd1;
				end
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_ff <= RX_WAIT_START;
			sample_count_ff <= 3'd0;
			bit_count_ff <= 3'd0;
			clock_divider <= '0;
			rx_sync_prev <= 1'b1;
		end
		else
		begin
			state_ff <= state_nxt;
			sample_count_ff <= sample_count_nxt;
			bit_count_ff <= bit_count_nxt;
			rx_sync_prev <= rx_sync;

			// Free-running oversample tick
			if (sample_enable)
				clock_divider <= DIV_RELOAD;
			else
				clock_divider <= clock_divider - 1'b1;
		end
	end

	// Data arrives LSB first, so shift in from the top
	always_ff @(posedge clk)
	begin
		if (do_shift)
			shift_register <= {rx_sync, shift_register[7:1]};
	end

endmodule

// ==== src/uart_settings.svh ====
// ====================
// UART build settings
// Baud divider and receive FIFO depth
// ====================
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Clocks per oversample tick, eight ticks make one bit
`define UART_BAUD_DIVIDE 4

// Log2 of the receive FIFO depth
`define UART_FIFO_ADDR_BITS 2

`endif

// ==== src/uart_transmit.sv ====
// ====================
// UART transmitter
// Sends one 8N1 frame per accepted write
// ====================
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_transmit
	(input                          clk,
	input                           reset,
	input uart_pkg::uart_char_t     tx_data,
	input logic                     tx_write,
	output logic                    uart_tx,
	output logic                    tx_busy);

	import uart_pkg::*;

	localparam int DIV_BITS = $clog2(`UART_BAUD_DIVIDE + 1);
	localparam logic [DIV_BITS-1:0] DIV_RELOAD = DIV_BITS'(`UART_BAUD_DIVIDE - 1);

	tx_state_t state_ff;
	tx_state_t state_nxt;
	logic [DIV_BITS-1:0] clock_divider_ff;
	logic [DIV_BITS-1:0] clock_divider_nxt;
	logic [2:0] sample_count_ff;
	logic [2:0] sample_count_nxt;
	logic [2:0] bit_count_ff;
	logic [2:0] bit_count_nxt;
	uart_char_t shift_ff;
	uart_char_t shift_nxt;
	logic tx_bit_ff;
	logic tx_bit_nxt;
	logic tick;
	logic bit_done;

	assign tick = clock_divider_ff == '0;
	// Eighth tick closes the current bit
	assign bit_done = tick && sample_count_ff == 3'd0;

	always_comb
	begin
		state_nxt = state_ff;
		bit_count_nxt = bit_count_ff;
		shift_nxt = shift_ff;
		tx_bit_nxt = tx_bit_ff;
		clock_divider_nxt = tick ? DIV_RELOAD : clock_divider_ff - 1'b1;
		sample_count_nxt = sample_count_ff;
		if (tick)
			sample_count_nxt = (sample_count_ff == 3'd0) ? 3'd7 : sample_count_ff - 3'd1;

		unique case (state_ff)
			TX_IDLE:
			begin
				if (tx_write)
				begin
					// Restart the bit timing at acceptance
					state_nxt = TX_START_BIT;
					shift_nxt = tx_data;
					tx_bit_nxt = 1'b0;
					clock_divider_nxt = DIV_RELOAD;
					sample_count_nxt = 3'd7;
				end
			end

			TX_START_BIT:
			begin
				if (bit_done)
				begin
					state_nxt = TX_DATA_BITS;
					bit_count_nxt = 3'd0;
					tx_bit_nxt = shift_ff[0];
				end
			end

			TX_DATA_BITS:
			begin
				if (bit_done)
				begin
					if (bit_count_ff == 3'd7)
					begin
						state_nxt = TX_STOP_BIT;
						tx_bit_nxt = 1'b1;
					end
					else
					begin
						bit_count_nxt = bit_count_ff + 3'd1;
						shift_nxt = shift_ff >> 1;
						tx_bit_nxt = shift_ff[1];
					end
				end
			end

			TX_STOP_BIT:
			begin
				if (bit_done)
					state_nxt = TX_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_ff <= TX_IDLE;
			clock_divider_ff <= '0;
			sample_count_ff <= 3'd0;
			bit_count_ff <= 3'd0;
			tx_bit_ff <= 1'b1;
		end
		else
		begin
			state_ff <= state_nxt;
			clock_divider_ff <= clock_divider_nxt;
			sample_count_ff <= sample_count_nxt;
			bit_count_ff <= bit_count_nxt;
			tx_bit_ff <= tx_bit_nxt;
		end
	end

	always_ff @(posedge clk)
		shift_ff <= shift_nxt;

	// Line driven from a flop, so no glitches between bits
	assign uart_tx = tx_bit_ff;
	assign tx_busy = state_ff != TX_IDLE;

endmodule

// ==== uart_core.f ====
+incdir+src
+incdir+bench
src/uart_pkg.sv
src/synchronizer.sv
src/uart_receive.sv
src/rx_fifo.sv
src/uart_transmit.sv
src/uart_core.sv
bench/uart_core_tb.sv
